/* compile.f */
logic/genesis_pkg.sv
logic/rom_load_if.sv
logic/core_settings.sv
logic/region_detect.sv
logic/cart_quirks.sv
logic/pad_mapper.sv
logic/genesis_ctrl_top.sv
tb/tb_genesis_ctrl.sv

/* logic/cart_quirks.sv */
// cartridge serial capture from the rom header
// per-title quirk flags and lightgun settings lookup

module cart_quirks (
    input  logic                clk_74a,
    input  logic                pll_core_locked,
    rom_load_if.watcher         rom,
    output genesis_pkg::quirk_t quirks,
    output logic                lightgun_type,
    output logic [7:0]          sensor_delay
);
    import genesis_pkg::*;

    serial_t    serial;
    logic       dl_q;
    quirk_t     hit_quirks;
    logic       hit_type;
    logic [7:0] hit_delay;
    logic [7:0] lo;
    logic [7:0] hi;

    assign lo = rom.data[7:0];
    assign hi = rom.data[15:8];

    // header words are big endian, bytes swap on the way in
    always_ff @(posedge clk_74a) begin
        if (rom.take) begin
            case (rom.addr)
                serial_first_addr: serial[63:56] <= hi;
                serial_word1_addr: serial[55:40] <= {lo, hi};
                serial_word2_addr: serial[39:24] <= {lo, hi};
                serial_word3_addr: serial[23:8]  <= {lo, hi};
                serial_last_addr:  serial[7:0]   <= lo;
                default: ;
            endcase
        end
    end

    always_comb begin
        hit_quirks = '0;
        hit_type   = 1'b0;
        hit_delay  = default_sensor_delay;
        for (int i = 0; i < $size(quirk_table); i++) begin
            if (serial == quirk_table[i].serial) hit_quirks = quirk_table[i].quirks;
        end
        for (int i = 0; i < $size(lightgun_table); i++) begin
            if (serial == lightgun_table[i].serial) begin
                hit_type  = lightgun_table[i].gun_type;
                hit_delay = lightgun_table[i].delay;
            end
        end
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            dl_q          <= 1'b0;
            quirks        <= '0;
            lightgun_type <= 1'b0;
            sensor_delay  <= default_sensor_delay;
        end else begin
            dl_q <= rom.download;
            if (rom.download && !dl_q) quirks <= '0;  // new cart
            if (rom.take && rom.addr == serial_check_addr) begin
                quirks        <= hit_quirks;
                lightgun_type <= hit_type;
                sensor_delay  <= hit_delay;
            end
        end
    end

    a_quirk_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $onehot0(quirks));

endmodule

/* logic/core_settings.sv */
// bridge written settings registers
// delayed core reset request and menu pause
// bridge read-back mux

module core_settings (
    input  logic                             clk_74a,
    input  logic                             pll_core_locked,
    input  logic [genesis_pkg::bridge_w-1:0] bridge_addr,
    input  logic [genesis_pkg::bridge_w-1:0] bridge_wr_data,
    input  logic                             bridge_wr,
    input  logic                             bridge_rd,
    output logic [genesis_pkg::bridge_w-1:0] bridge_rd_data,
    input  genesis_pkg::region_t             region_req,
    input  logic                             host_reset_n,
    input  logic                             in_menu,
    input  logic                             download,
    input  logic                             region_set,
    output logic [1:0]                       audio_filter,
    output logic [1:0]                       turbo,
    output logic                             fm_chip,
    output logic                             multitap,
    output logic                             ar_correct,
    output logic                             composite,
    output logic                             auto_composite,
    output logic                             obj_limit_high,
    output logic                             fm_en,
    output logic                             psg_en,
    output logic                             hifi_pcm_en,
    output logic                             m30_map,
    output logic                             menu_pause,
    output logic                             lightgun_en,
    output logic                             show_crosshair,
    output logic [7:0]                       aim_speed,
    output logic                             pause,
    output logic                             core_reset_n
);
    import genesis_pkg::*;

    logic [reset_delay_w-1:0] free_cnt;     // seeds the delay length
    logic [reset_delay_w+3:0] reset_delay;
    logic                     started;      // low until first clock out of reset

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            audio_filter   <= 2'd0;
            turbo          <= 2'd0;
            fm_chip        <= 1'b0;
            multitap       <= 1'b0;
            ar_correct     <= 1'b0;
            composite      <= 1'b0;
            auto_composite <= 1'b0;
            obj_limit_high <= 1'b1;
            fm_en          <= 1'b1;
            psg_en         <= 1'b1;
            hifi_pcm_en    <= 1'b1;
            m30_map        <= 1'b0;
            menu_pause     <= 1'b0;
            lightgun_en    <= 1'b0;
            show_crosshair <= 1'b1;
            aim_speed      <= 8'd4;
            free_cnt       <= '0;
            reset_delay    <= '0;
            started        <= 1'b0;
        end else begin
            started  <= 1'b1;
            free_cnt <= free_cnt + 1'b1;
            if (!in_menu && reset_delay != '0)
                reset_delay <= reset_delay - 1'b1;  // frozen while host menu is up

            if (bridge_wr) begin
                case (bridge_addr)
                    addr_audio_filter: audio_filter   <= bridge_wr_data[1:0];
                    addr_fm_chip:      fm_chip        <= bridge_wr_data[0];
                    addr_turbo:        turbo          <= bridge_wr_data[1:0];
                    addr_multitap:     multitap       <= bridge_wr_data[0];
                    addr_ar_correct:   ar_correct     <= bridge_wr_data[0];
                    addr_composite: begin
                        composite      <= bridge_wr_data[0];
                        auto_composite <= bridge_wr_data[1];
                    end
                    addr_obj_limit:    obj_limit_high <= bridge_wr_data[0];
                    addr_fm_en:        fm_en          <= bridge_wr_data[0];
                    addr_psg_en:       psg_en         <= bridge_wr_data[0];
                    addr_hifi_pcm:     hifi_pcm_en    <= bridge_wr_data[0];
                    addr_reset_req: begin
                        if (bridge_wr_data != '0)
                            reset_delay <= {free_cnt, 4'hF};
                    end
                    addr_m30_map:      m30_map        <= bridge_wr_data[0];
                    addr_menu_pause:   menu_pause     <= bridge_wr_data[0];
                    addr_lightgun_en:  lightgun_en    <= bridge_wr_data[0];
                    addr_crosshair:    show_crosshair <= bridge_wr_data[0];
                    addr_aim_speed:    aim_speed      <= bridge_wr_data[7:0];
                    default: ;
                endcase
            end
        end
    end

    assign core_reset_n = started && host_reset_n && !download && !region_set
                          && (reset_delay == '0);
    assign pause = menu_pause && in_menu;

    // only the detected region is readable
    assign bridge_rd_data = (bridge_addr == addr_region) ?
                            {{(bridge_w-2){1'b0}}, region_req} : '0;

    a_bridge_excl: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        !(bridge_wr && bridge_rd));

endmodule

/* logic/genesis_ctrl_top.sv */
// control plane top level
// settings bank, region detect, cart quirks and pad remap

module genesis_ctrl_top (
    input  logic                               clk_74a,
    input  logic                               pll_core_locked,
    input  logic [genesis_pkg::bridge_w-1:0]   bridge_addr,
    input  logic                               bridge_rd,
    output logic [genesis_pkg::bridge_w-1:0]   bridge_rd_data,
    input  logic                               bridge_wr,
    input  logic [genesis_pkg::bridge_w-1:0]   bridge_wr_data,
    input  logic                               rom_wr,
    input  logic [genesis_pkg::rom_addr_w-1:0] rom_addr,
    input  logic [genesis_pkg::rom_data_w-1:0] rom_data,
    input  logic                               cart_download,
    input  logic                               host_reset_n,
    input  logic                               in_menu,
    input  logic [genesis_pkg::key_w-1:0]      cont1_key,
    input  logic [genesis_pkg::key_w-1:0]      cont2_key,
    input  logic [genesis_pkg::key_w-1:0]      cont3_key,
    input  logic [genesis_pkg::key_w-1:0]      cont4_key,
    output logic [1:0]                         audio_filter,
    output logic [1:0]                         turbo,
    output logic                               fm_chip,
    output logic                               multitap,
    output logic                               ar_correct,
    output logic                               composite,
    output logic                               auto_composite,
    output logic                               obj_limit_high,
    output logic                               fm_en,
    output logic                               psg_en,
    output logic                               hifi_pcm_en,
    output logic                               m30_map,
    output logic                               menu_pause,
    output logic                               lightgun_en,
    output logic                               show_crosshair,
    output logic [7:0]                         aim_speed,
    output logic                               pause,
    output logic                               core_reset_n,
    output genesis_pkg::quirk_t                quirks,
    output logic                               lightgun_type,
    output logic [7:0]                         sensor_delay,
    output logic [genesis_pkg::joy_w-1:0]      joystick_0,
    output logic [genesis_pkg::joy_w-1:0]      joystick_1,
    output logic [genesis_pkg::joy_w-1:0]      joystick_2,
    output logic [genesis_pkg::joy_w-1:0]      joystick_3
);

    genesis_pkg::region_t region_req;
    logic                 region_set;  // holds the core in reset after a header

    rom_load_if i_rom (
        .wr       (rom_wr),
        .addr     (rom_addr),
        .data     (rom_data),
        .download (cart_download)
    );

    core_settings i_settings (
        .clk_74a, .pll_core_locked,
        .bridge_addr, .bridge_wr_data, .bridge_wr, .bridge_rd, .bridge_rd_data,
        .region_req, .host_reset_n, .in_menu,
        .download (cart_download),
        .region_set,
        .audio_filter, .turbo, .fm_chip, .multitap, .ar_correct,
        .composite, .auto_composite, .obj_limit_high, .fm_en, .psg_en,
        .hifi_pcm_en, .m30_map, .menu_pause, .lightgun_en, .show_crosshair,
        .aim_speed, .pause, .core_reset_n
    );

    region_detect i_region (
        .clk_74a, .pll_core_locked,
        .rom (i_rom.watcher),
        .region_req, .region_set
    );

    cart_quirks i_quirks (
        .clk_74a, .pll_core_locked,
        .rom (i_rom.watcher),
        .quirks, .lightgun_type, .sensor_delay
    );

    pad_mapper i_pads (
        .cont1_key, .cont2_key, .cont3_key, .cont4_key,
        .m30_map, .lightgun_en,
        .joystick_0, .joystick_1, .joystick_2, .joystick_3
    );

endmodule

/* logic/genesis_pkg.sv */
// shared definitions for the console control plane
// bus widths, bridge address map, rom header offsets
// region enum, quirk flags and per-title lookup tables

package genesis_pkg;

    localparam int bridge_w      = 32;
    localparam int rom_addr_w    = 25;
    localparam int rom_data_w    = 16;
    localparam int key_w         = 16;
    localparam int joy_w         = 12;
    localparam int reset_delay_w = 8;  // counter bits, 4 low ones appended

    //////////////////////////////
    // bridge address map
    localparam logic [31:0] addr_audio_filter = 32'h00F0_0000;
    localparam logic [31:0] addr_fm_chip      = 32'h00A0_0000;
    localparam logic [31:0] addr_turbo        = 32'h00C0_0000;
    localparam logic [31:0] addr_region       = 32'h00E0_0000;  // read only
    localparam logic [31:0] addr_multitap     = 32'h0000_0000;
    localparam logic [31:0] addr_ar_correct   = 32'h0000_0010;
    localparam logic [31:0] addr_composite    = 32'h0000_0020;
    localparam logic [31:0] addr_obj_limit    = 32'h0000_0030;
    localparam logic [31:0] addr_fm_en        = 32'h0000_0040;
    localparam logic [31:0] addr_psg_en       = 32'h0000_0050;
    localparam logic [31:0] addr_hifi_pcm     = 32'h0000_0060;
    localparam logic [31:0] addr_reset_req    = 32'h0000_0070;
    localparam logic [31:0] addr_m30_map      = 32'h0000_0080;
    localparam logic [31:0] addr_menu_pause   = 32'h0000_0090;
    localparam logic [31:0] addr_lightgun_en  = 32'h0000_0100;
    localparam logic [31:0] addr_crosshair    = 32'h0000_0104;
    localparam logic [31:0] addr_aim_speed    = 32'h0000_0108;

    //////////////////////////////
    // rom header byte offsets
    localparam logic [rom_addr_w-1:0] hdr_region_addr    = 'h1F0;
    localparam logic [rom_addr_w-1:0] hdr_region2_addr   = 'h1F2;
    localparam logic [rom_addr_w-1:0] hdr_done_addr      = 'h200;
    localparam logic [rom_addr_w-1:0] serial_first_addr  = 'h182;
    localparam logic [rom_addr_w-1:0] serial_word1_addr  = 'h184;
    localparam logic [rom_addr_w-1:0] serial_word2_addr  = 'h186;
    localparam logic [rom_addr_w-1:0] serial_word3_addr  = 'h188;
    localparam logic [rom_addr_w-1:0] serial_last_addr   = 'h18A;
    localparam logic [rom_addr_w-1:0] serial_check_addr  = 'h18C;

    typedef enum logic [1:0] {
        region_jp = 2'd0,
        region_us = 2'd1,
        region_eu = 2'd2
    } region_t;

    typedef struct packed {
        logic sram;
        logic sram00;
        logic eeprom;
        logic noram;
        logic fifo;
        logic pier;
        logic svp;
        logic fmbusy;
        logic schan;
    } quirk_t;

    typedef logic [63:0] serial_t;  // eight ascii chars

    typedef struct packed {
        serial_t serial;
        quirk_t  quirks;
    } quirk_entry_t;

    typedef struct packed {
        serial_t    serial;
        logic       gun_type;
        logic [7:0] delay;
    } gun_entry_t;

    localparam logic [7:0] default_sensor_delay = 8'd44;

    localparam quirk_entry_t quirk_table [8] = '{
        '{serial: "T-081276", quirks: '{sram: 1'b1, default: 1'b0}},
        '{serial: "MK-1215 ", quirks: '{eeprom: 1'b1, default: 1'b0}},
        '{serial: "T-113016", quirks: '{noram: 1'b1, default: 1'b0}},
        '{serial: "T-89016 ", quirks: '{fifo: 1'b1, default: 1'b0}},
        '{serial: "MK-1229 ", quirks: '{svp: 1'b1, default: 1'b0}},
        '{serial: "T-35036 ", quirks: '{fmbusy: 1'b1, default: 1'b0}},
        '{serial: " GM 0000", quirks: '{sram00: 1'b1, default: 1'b0}},
        '{serial: "T-574023", quirks: '{pier: 1'b1, default: 1'b0}}
    };

    localparam gun_entry_t lightgun_table [2] = '{
        '{serial: "T-95096-", gun_type: 1'b1, delay: 8'd52},
        '{serial: "MK-1533 ", gun_type: 1'b0, delay: 8'd100}
    };

endpackage

/* logic/pad_mapper.sv */
// controller key bitmaps to console joystick words
// standard or alternate six-button layout, pad 1 start masked for lightgun

module pad_mapper (
    input  logic [genesis_pkg::key_w-1:0] cont1_key,
    input  logic [genesis_pkg::key_w-1:0] cont2_key,
    input  logic [genesis_pkg::key_w-1:0] cont3_key,
    input  logic [genesis_pkg::key_w-1:0] cont4_key,
    input  logic                          m30_map,
    input  logic                          lightgun_en,
    output logic [genesis_pkg::joy_w-1:0] joystick_0,
    output logic [genesis_pkg::joy_w-1:0] joystick_1,
    output logic [genesis_pkg::joy_w-1:0] joystick_2,
    output logic [genesis_pkg::joy_w-1:0] joystick_3
);
    import genesis_pkg::*;

    // Z Y X mode start B C A up down left right, msb first
    function automatic logic [joy_w-1:0] map_pad(
        input logic [key_w-1:0] k,
        input logic             alt,
        input logic             no_start
    );
        return {
            alt ? k[10] : k[9],     // Z
            alt ? k[7]  : k[6],     // Y
            alt ? k[6]  : k[8],     // X
            k[14],                  // mode from select
            no_start ? 1'b0 : k[15],
            alt ? k[11] : k[4],     // B
            k[5],                   // C, same in both layouts
            alt ? k[4]  : k[7],     // A
            k[0], k[1], k[2], k[3]  // dpad
        };
    endfunction

    assign joystick_0 = map_pad(cont1_key, m30_map, lightgun_en);
    assign joystick_1 = map_pad(cont2_key, m30_map, 1'b0);
    assign joystick_2 = map_pad(cont3_key, m30_map, 1'b0);
    assign joystick_3 = map_pad(cont4_key, m30_map, 1'b0);

endmodule

/* logic/region_detect.sv */
// rom header region parser
// collects J/U/E flags while the header streams in
// picks the region request once the header is complete

module region_detect (
    input  logic                 clk_74a,
    input  logic                 pll_core_locked,
    rom_load_if.watcher          rom,
    output genesis_pkg::region_t region_req,
    output logic                 region_set
);
    import genesis_pkg::*;

    logic       dl_q;         // download, one cycle late
    logic       hdr_ready;
    logic       ready_q;
    logic [2:0] flags;        // {e, u, j}
    logic [2:0] flags_main;   // next flags at hdr_region_addr
    logic [7:0] lo;
    logic [7:0] hi;
    logic [3:0] hrgn;

    // letter code to {e, u, j}
    function automatic logic [2:0] letter_euj(input logic [7:0] c);
        case (c)
            "J":     return 3'b001;
            "U":     return 3'b010;
            "E":     return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    assign lo   = rom.data[7:0];
    assign hi   = rom.data[15:8];
    assign hrgn = lo[3:0] - 4'd7;  // 'A'..'F' down to 0xA..0xF

    always_comb begin
        if (letter_euj(lo) != 3'b000)
            flags_main = flags | letter_euj(lo);
        else if (lo >= "0" && lo <= "9")
            flags_main = {lo[3], lo[2], lo[0]};     // hex digit region mask
        else if (lo >= "A" && lo <= "F")
            flags_main = {hrgn[3], hrgn[2], hrgn[0]};
        else
            flags_main = flags;
        flags_main = flags_main | letter_euj(hi);
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            dl_q       <= 1'b0;
            hdr_ready  <= 1'b0;
            ready_q    <= 1'b0;
            flags      <= 3'b000;
            region_req <= region_jp;
            region_set <= 1'b0;
        end else begin
            dl_q    <= rom.download;
            ready_q <= hdr_ready;

            if (rom.download && !dl_q) flags <= 3'b000;
            if (!rom.download && dl_q) hdr_ready <= 1'b0;

            if (rom.take) begin
                if (rom.addr == hdr_region_addr)  flags <= flags_main;
                if (rom.addr == hdr_region2_addr) flags <= flags | letter_euj(lo);
                if (rom.addr == hdr_done_addr)    hdr_ready <= 1'b1;
            end

            if (hdr_ready && !ready_q) begin
                region_set <= 1'b1;
                if (flags[1])      region_req <= region_us;
                else if (flags[2]) region_req <= region_eu;
                else if (flags[0]) region_req <= region_jp;
                else               region_req <= region_us;  // no marking, assume US
            end
            if (!hdr_ready && ready_q) region_set <= 1'b0;
        end
    end

    a_region_legal: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        region_req != 2'd3);

endmodule

/* logic/rom_load_if.sv */
// rom write stream as seen by the header watchers
// carries the word strobe, byte address, data and download level

interface rom_load_if (
    input logic                               wr,
    input logic [genesis_pkg::rom_addr_w-1:0] addr,
    input logic [genesis_pkg::rom_data_w-1:0] data,
    input logic                               download
);

    logic take;  // word accepted this cycle

    assign take = wr && download;

    modport watcher (
        input wr,
        input addr,
        input data,
        input download,
        input take
    );

endinterface

/* tb/genesis_stim.txt */
# all fields hex. W addr data settings | C settings | R addr rd_data | D download | L addr data
# S serial | Q quirks type delay | P count m30 gun | H host_reset_n | M in_menu | K core_reset_n | N cycles | U
C 000f104
W f00000 2 100f104
W a00000 1 110f104
W c00000 3 170f104
W 0 1 178f104
W 10 1 17cf104
W 20 3 17ff104
W 30 0 17f7104
W 40 0 17f3104
W 50 0 17f1104
W 60 0 17f0104
W 80 1 17f0904
W 90 1 17f0d04
W 100 1 17f0f04
W 104 0 17f0e04
W 108 a5 17f0ea5
P 10 1 1
W 80 0 17f06a5
P 10 0 1
W 100 0 17f04a5
P 10 0 0
# header regions U, digit 8, J
D 1
K 0
L 1f0 2055
L 200 0
R e00000 1
D 0
K 0
N 2
K 1
D 1
L 1f0 2038
L 200 0
R e00000 2
D 0
D 1
L 1f0 204a
L 200 0
R e00000 0
D 0
# serials MK-1215, T-95096-, unknown
D 1
S 4d4b2d3132313520
Q 040 0 2c
S 542d39353039362d
Q 000 1 34
S 542d303030303020
Q 000 0 2c
D 0
H 0
K 0
H 1
K 1
W 70 1 17f04a5
K 0
M 1
N 40
K 0
M 0
U
K 1

/* tb/tb_genesis_ctrl.sv */
// testbench for the console control plane top level
// runs the command list in tb/genesis_stim.txt against the DUT
// reference models for pad layouts and header serial words

module tb_genesis_ctrl;
    import genesis_pkg::*;

    // joystick source bit per output bit, Z first, 4 bits each
    localparam logic [47:0] std_src = {4'd9, 4'd6, 4'd8, 4'd14, 4'd15, 4'd4,
                                       4'd5, 4'd7, 4'd0, 4'd1, 4'd2, 4'd3};
    localparam logic [47:0] alt_src = {4'd10, 4'd7, 4'd6, 4'd14, 4'd15, 4'd11,
                                       4'd5, 4'd4, 4'd0, 4'd1, 4'd2, 4'd3};

    logic clk_74a = 1'b0;
    logic pll_core_locked;
    logic [bridge_w-1:0] bridge_addr, bridge_wr_data, bridge_rd_data;
    logic bridge_rd, bridge_wr;
    logic rom_wr, cart_download, host_reset_n, in_menu;
    logic [rom_addr_w-1:0] rom_addr;
    logic [rom_data_w-1:0] rom_data;
    logic [key_w-1:0] cont1_key, cont2_key, cont3_key, cont4_key;
    logic [1:0] audio_filter, turbo;
    logic fm_chip, multitap, ar_correct, composite, auto_composite, obj_limit_high;
    logic fm_en, psg_en, hifi_pcm_en, m30_map, menu_pause, lightgun_en, show_crosshair;
    logic [7:0] aim_speed, sensor_delay;
    logic pause, core_reset_n, lightgun_type;
    quirk_t quirks;
    logic [joy_w-1:0] joystick_0, joystick_1, joystick_2, joystick_3;
    logic [24:0] settings_vec;

    logic [7:0]  ops[$];       // parsed commands
    logic [63:0] fa[$], fb[$], fc[$];
    logic [31:0] rng;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;

    genesis_ctrl_top i_dut (.*);

    always #5 clk_74a = ~clk_74a;

    // same field order as the stim file settings column
    assign settings_vec = {audio_filter, turbo, fm_chip, multitap, ar_correct, composite,
                           auto_composite, obj_limit_high, fm_en, psg_en, hifi_pcm_en,
                           m30_map, menu_pause, lightgun_en, show_crosshair, aim_speed};

    always @(posedge clk_74a) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [11:0] expected_joy(input logic [15:0] k, input logic alt,
                                                 input logic no_start);
        logic [47:0] src;
        logic [11:0] j;
        src = alt ? alt_src : std_src;
        for (int b = 0; b < 12; b++)
            j[b] = k[src[b*4 +: 4]];
        if (no_start)
            j[7] = 1'b0;  // start bit
        return j;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected 'h%0h actual 'h%0h", $time, name, exp, got);
        end
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [24:0] vec);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        @(negedge clk_74a);
        check_val("settings", vec, settings_vec);
    endtask

    task automatic bridge_read(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk_74a);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(negedge clk_74a);
        check_val("bridge_rd_data", exp, bridge_rd_data);
        @(posedge clk_74a);
        bridge_addr <= addr_aim_speed;  // settings registers read as zero
        bridge_rd   <= 1'b0;
        @(negedge clk_74a);
        check_val("bridge_rd_data", '0, bridge_rd_data);
    endtask

    task automatic rom_write(input logic [rom_addr_w-1:0] addr, input logic [15:0] data);
        @(posedge clk_74a);
        rom_addr <= addr;
        rom_data <= data;
        rom_wr   <= 1'b1;
        @(posedge clk_74a);
        rom_wr <= 1'b0;
    endtask

    // big endian header words, first char alone in the high byte
    task automatic load_serial(input logic [63:0] s);
        rom_write(serial_first_addr, {s[63:56], 8'h00});
        rom_write(serial_word1_addr, {s[47:40], s[55:48]});
        rom_write(serial_word2_addr, {s[31:24], s[39:32]});
        rom_write(serial_word3_addr, {s[15:8], s[23:16]});
        rom_write(serial_last_addr, {8'h00, s[7:0]});
        rom_write(serial_check_addr, 16'h0000);
    endtask

    task automatic pad_sweep(input int n, input logic alt, input logic gun);
        logic [15:0] k [4];
        logic [11:0] e [4];
        for (int p = 0; p < n; p++) begin
            for (int j = 0; j < 4; j++) begin
                rng  = xorshift(rng);
                k[j] = rng[15:0];
                e[j] = expected_joy(k[j], alt, gun && j == 0);
            end
            @(posedge clk_74a);
            cont1_key <= k[0];
            cont2_key <= k[1];
            cont3_key <= k[2];
            cont4_key <= k[3];
            @(negedge clk_74a);
            check_val("joystick_0", e[0], joystick_0);
            check_val("joystick_1", e[1], joystick_1);
            check_val("joystick_2", e[2], joystick_2);
            check_val("joystick_3", e[3], joystick_3);
        end
    endtask

    //////////////////////////////
    // stimulus

    initial begin
        int fd;
        int n;
        int stim_cycles;
        logic [7:0] op;
        logic [63:0] a, b, c;
        logic [8*128-1:0] junk;
        logic [24:0] exp_settings;  // last settings column from the stim file

        pll_core_locked = 1'b0;
        bridge_addr = '0;
        bridge_wr_data = '0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        rom_wr = 1'b0;
        rom_addr = '0;
        rom_data = '0;
        cart_download = 1'b0;
        host_reset_n = 1'b1;
        in_menu = 1'b1;  // host menu up at power on
        cont1_key = '0;
        cont2_key = '0;
        cont3_key = '0;
        cont4_key = '0;
        rng = 32'hf638_6b63;
        stim_cycles = 0;
        exp_settings = '0;

        fd = $fopen("tb/genesis_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file tb/genesis_stim.txt");
            $display("Simulation FAILED");
            $finish;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            a = '0;
            b = '0;
            c = '0;
            if (op == "#") begin
                n = $fgets(junk, fd);  // comment line
            end else begin
                case (op)
                    "W", "Q", "P": n = $fscanf(fd, "%h %h %h", a, b, c);
                    "R", "L":      n = $fscanf(fd, "%h %h", a, b);
                    "U":           n = 0;
                    default:       n = $fscanf(fd, "%h", a);
                endcase
                ops.push_back(op);
                fa.push_back(a);
                fb.push_back(b);
                fc.push_back(c);
                stim_cycles += 2 + ((op == "P" || op == "N") ? int'(a) : 0)
                               + ((op == "S") ? 12 : 0);
            end
        end
        $fclose(fd);
        limit = 2 * stim_cycles + (1 << (reset_delay_w + 4));

        repeat (10) @(posedge clk_74a);
        @(negedge clk_74a);
        check_val("core_reset_n", 1'b0, core_reset_n);
        check_val("quirks", '0, quirks);
        check_val("lightgun_type", 1'b0, lightgun_type);
        check_val("pause", 1'b0, pause);  // menu pause is off by default
        @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        in_menu         <= 1'b0;

        for (int i = 0; i < ops.size(); i++) begin
            case (ops[i])
                "W": begin
                    bridge_write(fa[i][31:0], fb[i][31:0], fc[i][24:0]);
                    exp_settings = fc[i][24:0];
                end
                "C": begin
                    @(negedge clk_74a);
                    check_val("settings", fa[i][24:0], settings_vec);
                    exp_settings = fa[i][24:0];
                end
                "R": bridge_read(fa[i][31:0], fb[i][31:0]);
                "D": begin
                    @(posedge clk_74a);
                    cart_download <= fa[i][0];
                end
                "L": rom_write(fa[i][rom_addr_w-1:0], fb[i][15:0]);
                "S": load_serial(fa[i]);
                "Q": begin
                    @(negedge clk_74a);
                    check_val("quirks", fa[i][8:0], quirks);
                    check_val("lightgun_type", fb[i][0], lightgun_type);
                    check_val("sensor_delay", fc[i][7:0], sensor_delay);
                end
                "P": pad_sweep(int'(fa[i]), fb[i][0], fc[i][0]);
                "H": begin
                    @(posedge clk_74a);
                    host_reset_n <= fa[i][0];
                end
                "M": begin
                    @(posedge clk_74a);
                    in_menu <= fa[i][0];
                    @(negedge clk_74a);
                    // bit 10 of the settings column is menu_pause
                    check_val("pause", exp_settings[10] && fa[i][0], pause);
                end
                "K": begin
                    @(negedge clk_74a);
                    check_val("core_reset_n", fa[i][0], core_reset_n);
                end
                "N": repeat (int'(fa[i])) @(posedge clk_74a);
                "U": begin
                    while (core_reset_n !== 1'b1)
                        @(negedge clk_74a);  // bounded by the cycle limit
                end
                default: begin
                    errors++;
                    $display("unknown stimulus command '%c' at entry %0d", ops[i], i);
                end
            endcase
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
